/* verilog.f */
common/usb_bulk_pkg.sv
source/token_dispatch.sv
bulk/bulk_transfer_fsm.sv
source/handshake_issuer.sv
source/in_packet_sender.sv
source/usb_bulk_endpoint.sv
test/usb_bulk_chk.sv
test/usb_bulk_monitor.sv
test/tb_usb_bulk.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the USB bulk endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_usb_bulk -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^PASS: all tests$"; then
  exit 0
fi
exit 1

/* test/tb_usb_bulk.sv */
`timescale 1ns/10ps
module tb_usb_bulk;

  localparam int NUM_TOKENS = 150;
  localparam int CYCLE = 100;
  localparam logic [6:0] DEV_ADDR = 7'h2a;

  logic clock;
  logic reset;
  logic [6:0] usb_addr_i;
  logic tok_recv_i;
  logic [1:0] tok_type_i;
  logic [6:0] tok_addr_i;
  logic [3:0] tok_endp_i;
  logic hsk_recv_i;
  logic [1:0] hsk_type_i;
  logic hsk_send_o;
  logic hsk_sent_i;
  logic [1:0] hsk_type_o;
  logic usb_send_o;
  logic usb_busy_i;
  logic [1:0] usb_type_o;
  logic usb_tvalid_i;
  logic usb_tready_o;
  logic usb_tlast_i;
  logic [usb_bulk_pkg::BYTE_W-1:0] usb_tdata_i;
  logic usb_tvalid_o;
  logic usb_tready_i;
  logic usb_tlast_o;
  logic [usb_bulk_pkg::BYTE_W-1:0] usb_tdata_o;
  logic blk_in_ready_i;
  logic blk_out_ready_i;
  logic blk_tvalid_o;
  logic blk_tready_i;
  logic blk_tlast_o;
  logic [usb_bulk_pkg::BYTE_W-1:0] blk_tdata_o;
  logic blk_tvalid_i;
  logic blk_tready_o;
  logic blk_tlast_i;
  logic [usb_bulk_pkg::BYTE_W-1:0] blk_tdata_i;

  // Progress counters from the host and encoder models
  int busy_count = 0;
  int sent_count = 0;
  int last_count = 0;
  int assert_fails;

  usb_bulk_endpoint UUT (.*);

  usb_bulk_monitor mon (
    .clock(clock), .reset(reset), .usb_addr_i(usb_addr_i),
    .tok_recv_i(tok_recv_i), .tok_type_i(tok_type_i),
    .tok_addr_i(tok_addr_i), .tok_endp_i(tok_endp_i),
    .blk_in_ready_i(blk_in_ready_i), .blk_out_ready_i(blk_out_ready_i),
    .hsk_recv_i(hsk_recv_i), .hsk_type_i(hsk_type_i),
    .hsk_send_o_i(hsk_send_o), .hsk_sent_i(hsk_sent_i), .hsk_type_o_i(hsk_type_o),
    .usb_send_o_i(usb_send_o), .usb_type_o_i(usb_type_o),
    .usb_tvalid_i(usb_tvalid_i), .usb_tready_o_i(usb_tready_o),
    .usb_tlast_i(usb_tlast_i), .usb_tdata_i(usb_tdata_i),
    .usb_tvalid_o_i(usb_tvalid_o), .usb_tready_i(usb_tready_i),
    .usb_tlast_o_i(usb_tlast_o), .usb_tdata_o_i(usb_tdata_o),
    .blk_tvalid_o_i(blk_tvalid_o), .blk_tready_i(blk_tready_i),
    .blk_tlast_o_i(blk_tlast_o), .blk_tdata_o_i(blk_tdata_o),
    .blk_tvalid_i(blk_tvalid_i), .blk_tready_o_i(blk_tready_o),
    .blk_tlast_i(blk_tlast_i), .blk_tdata_i(blk_tdata_i)
  );

  bind handshake_issuer usb_bulk_chk hsk_hold_chk (
    .clock(clock), .reset(reset), .req_i(hsk_send_o), .ack_i(hsk_sent_i), .type_i(hsk_type_o)
  );
  bind in_packet_sender usb_bulk_chk send_hold_chk (
    .clock(clock), .reset(reset), .req_i(usb_send_o), .ack_i(usb_busy_i), .type_i(usb_type_o)
  );

  initial begin
    clock = 1'b0;
    forever #(CYCLE / 2) clock = ~clock;
  end

  task wait_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task drive_token(input logic [1:0] t, input logic [6:0] a, input logic [3:0] e);
    tok_type_i = t;
    tok_addr_i = a;
    tok_endp_i = e;
    tok_recv_i = 1'b1;
  endtask

  // Decoder side of an OUT packet, with a stray token during the data
  task send_out_packet(input int n, input int inject_at);
    logic moved;
    for (int k = 0; k < n; k++) begin
      usb_tvalid_i = 1'b1;
      usb_tdata_i = 8'($urandom);
      usb_tlast_i = k == n - 1;
      if (k == inject_at) begin
        drive_token(usb_bulk_pkg::TOK_IN, DEV_ADDR, usb_bulk_pkg::BULK_ENDPOINT);
      end
      moved = 1'b0;
      while (!moved) begin
        @(negedge clock);
        moved = usb_tready_o;
        @(posedge clock);
        #1;
        tok_recv_i = 1'b0;
      end
    end
    usb_tvalid_i = 1'b0;
    usb_tlast_i = 1'b0;
  endtask

  // Bulk source side of an IN packet
  task send_in_packet(input int n);
    logic moved;
    for (int k = 0; k < n; k++) begin
      blk_tvalid_i = 1'b1;
      blk_tdata_i = 8'($urandom);
      blk_tlast_i = k == n - 1;
      moved = 1'b0;
      while (!moved) begin
        @(negedge clock);
        moved = blk_tready_o;
        @(posedge clock);
        #1;
      end
    end
    blk_tvalid_i = 1'b0;
    blk_tlast_i = 1'b0;
  endtask

  task run_token();
    logic [1:0] t;
    logic [6:0] a;
    logic [3:0] e;
    logic ok;
    logic match;
    int n;
    int b0;
    int l0;
    int s0;
    t = 2'($urandom);
    a = ($urandom % 5 == 0) ? 7'($urandom) : DEV_ADDR;
    e = ($urandom % 5 == 0) ? 4'($urandom) : usb_bulk_pkg::BULK_ENDPOINT;
    ok = ($urandom % 4) != 0;
    match = (t == usb_bulk_pkg::TOK_IN || t == usb_bulk_pkg::TOK_OUT) &&
            a == DEV_ADDR && e == usb_bulk_pkg::BULK_ENDPOINT;
    blk_in_ready_i = ok;
    blk_out_ready_i = ok;
    b0 = busy_count;
    l0 = last_count;
    s0 = sent_count;
    drive_token(t, a, e);
    wait_cycles(1);
    tok_recv_i = 1'b0;
    if (!match) begin
      wait_cycles(3);
    end else if (t == usb_bulk_pkg::TOK_OUT) begin
      // FSM needs two clocks to reach out_rx or out_drain
      wait_cycles(2);
      n = 1 + int'($urandom % 16);
      send_out_packet(n, int'($urandom % 16));
      while (sent_count == s0) wait_cycles(1);
      wait_cycles(3);
    end else begin
      if (ok) begin
        send_in_packet(1 + int'($urandom % 16));
      end
      while (busy_count == b0 || (ok && last_count == l0)) wait_cycles(1);
      wait_cycles(int'($urandom % 3));
      hsk_type_i = ($urandom % 2 == 0) ? usb_bulk_pkg::HSK_ACK : usb_bulk_pkg::HSK_NAK;
      hsk_recv_i = 1'b1;
      wait_cycles(1);
      hsk_recv_i = 1'b0;
      wait_cycles(3);
    end
  endtask

  // Encoder takes a data packet request 1 to 3 cycles late
  initial begin : encoder_busy
    int d;
    usb_busy_i = 1'b0;
    forever begin
      @(negedge clock);
      if (usb_send_o === 1'b1 && !reset) begin
        d = 1 + int'($urandom % 3);
        repeat (d) @(posedge clock);
        #1 usb_busy_i = 1'b1;
        @(posedge clock);
        #1 usb_busy_i = 1'b0;
        busy_count++;
      end
    end
  end

  // Handshake sender reports done 1 to 3 cycles late
  initial begin : handshake_sent
    int d;
    hsk_sent_i = 1'b0;
    forever begin
      @(negedge clock);
      if (hsk_send_o === 1'b1 && !reset) begin
        d = 1 + int'($urandom % 3);
        repeat (d) @(posedge clock);
        #1 hsk_sent_i = 1'b1;
        @(posedge clock);
        #1 hsk_sent_i = 1'b0;
        sent_count++;
      end
    end
  end

  // Random back-pressure on both streams
  initial begin : stream_ready
    blk_tready_i = 1'b0;
    usb_tready_i = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      blk_tready_i = ($urandom % 4) != 0;
      usb_tready_i = ($urandom % 4) != 0;
    end
  end

  always @(negedge clock) begin
    if (!reset && usb_tvalid_o && usb_tready_i && usb_tlast_o) begin
      last_count++;
    end
  end

  initial begin : watchdog
    repeat (NUM_TOKENS * 60) @(posedge clock);
    $display("Timeout after %0d cycles, the token sequence did not finish", NUM_TOKENS * 60);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    void'($urandom(32'h1596));
    reset = 1'b1;
    usb_addr_i = DEV_ADDR;
    tok_recv_i = 1'b0;
    tok_type_i = usb_bulk_pkg::TOK_SOF;
    tok_addr_i = 7'd0;
    tok_endp_i = 4'd0;
    hsk_recv_i = 1'b0;
    hsk_type_i = usb_bulk_pkg::HSK_ACK;
    usb_tvalid_i = 1'b0;
    usb_tlast_i = 1'b0;
    usb_tdata_i = '0;
    blk_in_ready_i = 1'b0;
    blk_out_ready_i = 1'b0;
    blk_tvalid_i = 1'b0;
    blk_tlast_i = 1'b0;
    blk_tdata_i = '0;
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;
    wait_cycles(2);
    for (int i = 0; i < NUM_TOKENS; i++) begin
      run_token();
    end
    wait_cycles(5);
    assert_fails = UUT.u_handshake_issuer.hsk_hold_chk.fail_count +
                   UUT.u_in_packet_sender.send_hold_chk.fail_count;
    mon.report(assert_fails);
    if (mon.error_count + assert_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* test/usb_bulk_monitor.sv */
`timescale 1ns/10ps
module usb_bulk_monitor (
  input logic                            clock,
  input logic                            reset,
  input logic [6:0]                      usb_addr_i,
  input logic                            tok_recv_i,
  input logic [1:0]                      tok_type_i,
  input logic [6:0]                      tok_addr_i,
  input logic [3:0]                      tok_endp_i,
  input logic                            blk_in_ready_i,
  input logic                            blk_out_ready_i,
  input logic                            hsk_recv_i,
  input logic [1:0]                      hsk_type_i,
  input logic                            hsk_send_o_i,
  input logic                            hsk_sent_i,
  input logic [1:0]                      hsk_type_o_i,
  input logic                            usb_send_o_i,
  input logic [1:0]                      usb_type_o_i,
  input logic                            usb_tvalid_i,
  input logic                            usb_tready_o_i,
  input logic                            usb_tlast_i,
  input logic [usb_bulk_pkg::BYTE_W-1:0] usb_tdata_i,
  input logic                            usb_tvalid_o_i,
  input logic                            usb_tready_i,
  input logic                            usb_tlast_o_i,
  input logic [usb_bulk_pkg::BYTE_W-1:0] usb_tdata_o_i,
  input logic                            blk_tvalid_o_i,
  input logic                            blk_tready_i,
  input logic                            blk_tlast_o_i,
  input logic [usb_bulk_pkg::BYTE_W-1:0] blk_tdata_o_i,
  input logic                            blk_tvalid_i,
  input logic                            blk_tready_o_i,
  input logic                            blk_tlast_i,
  input logic [usb_bulk_pkg::BYTE_W-1:0] blk_tdata_i
);

  // Model of the open transaction and the shared toggle
  logic active = 1'b0;
  logic dir_in = 1'b0;
  logic src_ok = 1'b0;
  logic toggle = 1'b0;
  logic last_seen = 1'b0;
  logic send_seen = 1'b0;
  logic hsk_send_q = 1'b0;
  logic usb_send_q = 1'b0;
  // Last OUT beat was taken on the previous clock
  logic out_end_q = 1'b0;
  logic tok_match;
  logic [1:0] exp_pid;
  // Queued bytes as {last, data}
  logic [usb_bulk_pkg::BYTE_W:0] out_q[$];
  logic [usb_bulk_pkg::BYTE_W:0] in_q[$];
  logic [usb_bulk_pkg::BYTE_W:0] item;
  int reset_cycles = 0;
  int error_count = 0;
  int trans_count = 0;
  int byte_count = 0;

  assign tok_match = tok_recv_i &&
                     (tok_type_i == usb_bulk_pkg::TOK_IN || tok_type_i == usb_bulk_pkg::TOK_OUT) &&
                     tok_addr_i == usb_addr_i && tok_endp_i == usb_bulk_pkg::BULK_ENDPOINT;
  assign exp_pid = toggle ? usb_bulk_pkg::PID_DATA1 : usb_bulk_pkg::PID_DATA0;

  task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task report_failure(input string msg);
    error_count++;
    $display("Check failed at %0t: %s", $time, msg);
  endtask

  task report(input int assert_fails);
    $display("Summary: %0d transactions, %0d bytes, %0d check errors, %0d assertion failures",
             trans_count, byte_count, error_count, assert_fails);
  endtask

  // Everything sampled mid-cycle, where inputs and outputs are settled
  always @(negedge clock) begin
    if (reset) begin
      reset_cycles++;
      if (reset_cycles > 1 &&
          {usb_send_o_i, hsk_send_o_i, usb_tvalid_o_i, blk_tvalid_o_i, blk_tready_o_i} !==
          5'b00000) begin
        report_failure("output active or unknown during reset");
      end
      active = 1'b0;
      toggle = 1'b0;
      hsk_send_q = 1'b0;
      usb_send_q = 1'b0;
      out_end_q = 1'b0;
      out_q.delete();
      in_q.delete();
    end else begin
      // Matching token opens a transaction, others are dropped
      if (tok_match && !active) begin
        active = 1'b1;
        dir_in = tok_type_i == usb_bulk_pkg::TOK_IN;
        src_ok = dir_in ? blk_in_ready_i : blk_out_ready_i;
        last_seen = 1'b0;
        send_seen = 1'b0;
        trans_count++;
      end
      if (!active &&
          {usb_send_o_i, hsk_send_o_i, usb_tvalid_o_i, blk_tvalid_o_i} !== 4'b0000) begin
        report_failure("output activity with no transaction open");
      end

      // OUT bytes from the decoder to the sink
      if (active && !dir_in && usb_tvalid_i) begin
        // Decoder stalls only when the accepting sink stalls
        check_value("usb_tready_o", 32'(usb_tready_o_i), 32'(src_ok ? blk_tready_i : 1'b1));
        if (usb_tready_o_i && src_ok) begin
          out_q.push_back({usb_tlast_i, usb_tdata_i});
        end
      end
      if (blk_tvalid_o_i && !(active && !dir_in && src_ok)) begin
        report_failure("sink offered a beat it should not see");
      end else if (blk_tvalid_o_i && blk_tready_i) begin
        if (out_q.size() == 0) begin
          report_failure("sink received a beat the decoder never sent");
        end else begin
          item = out_q.pop_front();
          check_value("blk_tdata_o", 32'(blk_tdata_o_i), 32'(item[usb_bulk_pkg::BYTE_W-1:0]));
          check_value("blk_tlast_o", 32'(blk_tlast_o_i), 32'(item[usb_bulk_pkg::BYTE_W]));
          byte_count++;
        end
      end

      // Device handshake one cycle after the last OUT beat
      if ((hsk_send_o_i && !hsk_send_q) !== out_end_q) begin
        report_failure("handshake request not one cycle after the last OUT beat");
      end else if (out_end_q) begin
        check_value("hsk_type_o", 32'(hsk_type_o_i),
                    32'(src_ok ? usb_bulk_pkg::HSK_ACK : usb_bulk_pkg::HSK_NAK));
      end
      if (hsk_send_o_i && hsk_sent_i && active && !dir_in) begin
        if (out_q.size() != 0) begin
          report_failure("OUT bytes missing at the sink");
        end
        // Toggle moves only after our ACK
        if (src_ok) begin
          toggle = !toggle;
        end
        active = 1'b0;
      end

      // IN bytes leave in source order
      if (usb_tvalid_o_i && usb_tready_i) begin
        if (!(active && dir_in && src_ok) || in_q.size() == 0) begin
          report_failure("encoder received a byte it should not see");
        end else begin
          item = in_q.pop_front();
          check_value("usb_tdata_o", 32'(usb_tdata_o_i), 32'(item[usb_bulk_pkg::BYTE_W-1:0]));
          check_value("usb_tlast_o", 32'(usb_tlast_o_i), 32'(item[usb_bulk_pkg::BYTE_W]));
          if (usb_tlast_o_i) begin
            last_seen = 1'b1;
          end
          byte_count++;
        end
      end
      // Source sees ready only during an IN data packet
      if (blk_tready_o_i && !(active && dir_in && src_ok)) begin
        report_failure("source ready outside an IN data packet");
      end else if (blk_tvalid_i && blk_tready_o_i) begin
        in_q.push_back({blk_tlast_i, blk_tdata_i});
      end

      // Data packet request carries the model toggle's PID
      if (usb_send_o_i && !usb_send_q) begin
        if (!(active && dir_in) || send_seen) begin
          report_failure("unexpected data packet request");
        end else begin
          send_seen = 1'b1;
          check_value("usb_type_o", 32'(usb_type_o_i), 32'(exp_pid));
        end
      end

      // Host answer closes the IN transaction
      if (hsk_recv_i && active && dir_in) begin
        if (!send_seen || in_q.size() != 0 || (src_ok && !last_seen)) begin
          report_failure("IN packet incomplete at the host handshake");
        end
        if (hsk_type_i == usb_bulk_pkg::HSK_ACK) begin
          toggle = !toggle;
        end
        active = 1'b0;
      end

      out_end_q = active && !dir_in && usb_tvalid_i && usb_tready_o_i && usb_tlast_i;
      hsk_send_q = hsk_send_o_i;
      usb_send_q = usb_send_o_i;
    end
  end

endmodule

/* test/usb_bulk_chk.sv */
`timescale 1ns/10ps
module usb_bulk_chk (
  input logic       clock,
  input logic       reset,
  input logic       req_i,
  input logic       ack_i,
  input logic [1:0] type_i
);

  int hold_fails = 0;
  int type_fails = 0;
  int drop_fails = 0;
  int fail_count;

  assign fail_count = hold_fails + type_fails + drop_fails;

  // Request stays up until its acknowledge
  assert property (@(posedge clock) disable iff (reset) req_i && !ack_i |=> req_i)
    else begin
      hold_fails++;
      $error("request dropped before its acknowledge");
    end

  // Packet or handshake code is frozen while waiting
  assert property (@(posedge clock) disable iff (reset) req_i && !ack_i |=> $stable(type_i))
    else begin
      type_fails++;
      $error("request type changed while the request was held");
    end

  // Acknowledge clears the request on the next clock
  assert property (@(posedge clock) disable iff (reset) req_i && ack_i |=> !req_i)
    else begin
      drop_fails++;
      $error("request still up after its acknowledge");
    end

endmodule

/* source/usb_bulk_endpoint.sv */
`timescale 1ns/10ps
module usb_bulk_endpoint (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [6:0]                    usb_addr_i,
  // Decoded tokens
  input  logic                          tok_recv_i,
  input  logic [1:0]                    tok_type_i,
  input  logic [6:0]                    tok_addr_i,
  input  logic [3:0]                    tok_endp_i,
  // Handshakes from and to the host
  input  logic                          hsk_recv_i,
  input  logic [1:0]                    hsk_type_i,
  output logic                          hsk_send_o,
  input  logic                          hsk_sent_i,
  output logic [1:0]                    hsk_type_o,
  // Data packet request to the encoder
  output logic                          usb_send_o,
  input  logic                          usb_busy_i,
  output logic [1:0]                    usb_type_o,
  // OUT bytes from the decoder
  input  logic                          usb_tvalid_i,
  output logic                          usb_tready_o,
  input  logic                          usb_tlast_i,
  input  logic [usb_bulk_pkg::BYTE_W-1:0] usb_tdata_i,
  // IN bytes to the encoder
  output logic                          usb_tvalid_o,
  input  logic                          usb_tready_i,
  output logic                          usb_tlast_o,
  output logic [usb_bulk_pkg::BYTE_W-1:0] usb_tdata_o,
  // Bulk sink and source
  input  logic                          blk_in_ready_i,
  input  logic                          blk_out_ready_i,
  output logic                          blk_tvalid_o,
  input  logic                          blk_tready_i,
  output logic                          blk_tlast_o,
  output logic [usb_bulk_pkg::BYTE_W-1:0] blk_tdata_o,
  input  logic                          blk_tvalid_i,
  output logic                          blk_tready_o,
  input  logic                          blk_tlast_i,
  input  logic [usb_bulk_pkg::BYTE_W-1:0] blk_tdata_i
);

  logic                      start;
  usb_bulk_pkg::trans_dir_t  dir;
  logic                      ready;
  logic                      busy;
  logic                      toggle;
  logic                      in_last_done;
  usb_bulk_pkg::bulk_state_t state;

  // Sink sees beats only while accepting
  assign blk_tvalid_o = state == usb_bulk_pkg::out_rx && usb_tvalid_i;
  assign blk_tlast_o  = usb_tlast_i;
  assign blk_tdata_o  = usb_tdata_i;

  token_dispatch u_token_dispatch (
    .clock          (clock),
    .reset          (reset),
    .usb_addr_i     (usb_addr_i),
    .tok_recv_i     (tok_recv_i),
    .tok_type_i     (tok_type_i),
    .tok_addr_i     (tok_addr_i),
    .tok_endp_i     (tok_endp_i),
    .busy_i         (busy),
    .blk_in_ready_i (blk_in_ready_i),
    .blk_out_ready_i(blk_out_ready_i),
    .start_o        (start),
    .dir_o          (dir),
    .ready_o        (ready)
  );

  bulk_transfer_fsm u_bulk_transfer_fsm (
    .clock         (clock),
    .reset         (reset),
    .start_i       (start),
    .dir_i         (dir),
    .ready_i       (ready),
    .in_last_done_i(in_last_done),
    .usb_busy_i    (usb_busy_i),
    .usb_tvalid_i  (usb_tvalid_i),
    .usb_tready_o_i(usb_tready_o),
    .usb_tlast_i   (usb_tlast_i),
    .hsk_recv_i    (hsk_recv_i),
    .hsk_type_i    (hsk_type_i),
    .hsk_sent_i    (hsk_sent_i),
    .state_o       (state),
    .busy_o        (busy),
    .toggle_o      (toggle)
  );

  handshake_issuer u_handshake_issuer (
    .clock       (clock),
    .reset       (reset),
    .state_i     (state),
    .usb_tvalid_i(usb_tvalid_i),
    .blk_tready_i(blk_tready_i),
    .usb_tlast_i (usb_tlast_i),
    .hsk_sent_i  (hsk_sent_i),
    .usb_tready_o(usb_tready_o),
    .hsk_send_o  (hsk_send_o),
    .hsk_type_o  (hsk_type_o)
  );

  in_packet_sender u_in_packet_sender (
    .clock         (clock),
    .reset         (reset),
    .state_i       (state),
    .toggle_i      (toggle),
    .blk_tvalid_i  (blk_tvalid_i),
    .blk_tlast_i   (blk_tlast_i),
    .blk_tdata_i   (blk_tdata_i),
    .blk_tready_o  (blk_tready_o),
    .usb_busy_i    (usb_busy_i),
    .usb_tvalid_o  (usb_tvalid_o),
    .usb_tready_i  (usb_tready_i),
    .usb_tlast_o   (usb_tlast_o),
    .usb_tdata_o   (usb_tdata_o),
    .usb_send_o    (usb_send_o),
    .usb_type_o    (usb_type_o),
    .in_last_done_o(in_last_done)
  );

endmodule

/* source/in_packet_sender.sv */
`timescale 1ns/10ps
module in_packet_sender (
  input  logic                          clock,
  input  logic                          reset,
  input  usb_bulk_pkg::bulk_state_t     state_i,
  input  logic                          toggle_i,
  input  logic                          blk_tvalid_i,
  input  logic                          blk_tlast_i,
  input  logic [usb_bulk_pkg::BYTE_W-1:0] blk_tdata_i,
  output logic                          blk_tready_o,
  input  logic                          usb_busy_i,
  output logic                          usb_tvalid_o,
  input  logic                          usb_tready_i,
  output logic                          usb_tlast_o,
  output logic [usb_bulk_pkg::BYTE_W-1:0] usb_tdata_o,
  output logic                          usb_send_o,
  output logic [1:0]                    usb_type_o,
  output logic                          in_last_done_o
);

  logic                          skd_valid_q;
  logic                          skd_last_q;
  logic [usb_bulk_pkg::BYTE_W-1:0] skd_data_q;
  logic                          accept;
  logic                          out_free;
  logic                          send_start;
  logic                          req_done_q;

  // Source accepted only in in_tx, until the spare entry is taken
  assign blk_tready_o = state_i == usb_bulk_pkg::in_tx && !skd_valid_q;
  assign accept       = blk_tvalid_i && blk_tready_o;
  // Output entry empty or leaving this cycle
  assign out_free     = !usb_tvalid_o || usb_tready_i;
  assign in_last_done_o = usb_tvalid_o && usb_tready_i && usb_tlast_o;

  // Entry valid flags
  always_ff @(posedge clock) begin
    if (reset) begin
      usb_tvalid_o <= 1'b0;
      skd_valid_q  <= 1'b0;
    end else if (out_free) begin
      usb_tvalid_o <= skd_valid_q || accept;
      skd_valid_q  <= 1'b0;
    end else begin
      skd_valid_q <= skd_valid_q || accept;
    end
  end

  // Entry payloads, spare entry drains first
  always_ff @(posedge clock) begin
    if (out_free) begin
      usb_tlast_o <= skd_valid_q ? skd_last_q : blk_tlast_i;
      usb_tdata_o <= skd_valid_q ? skd_data_q : blk_tdata_i;
    end else if (accept) begin
      skd_last_q <= blk_tlast_i;
      skd_data_q <= blk_tdata_i;
    end
  end

  // First offered byte in in_tx, or the empty packet in in_zdp
  // Only once per transaction
  assign send_start = !req_done_q &&
                      (state_i == usb_bulk_pkg::in_tx && blk_tvalid_i ||
                       state_i == usb_bulk_pkg::in_zdp);

  always_ff @(posedge clock) begin
    if (reset) begin
      usb_send_o <= 1'b0;
      req_done_q <= 1'b0;
    end else begin
      if (state_i == usb_bulk_pkg::idle) begin
        req_done_q <= 1'b0;
      end else if (send_start) begin
        req_done_q <= 1'b1;
      end
      // Encoder busy acknowledges the request
      if (usb_busy_i) begin
        usb_send_o <= 1'b0;
      end else if (send_start) begin
        usb_send_o <= 1'b1;
      end
    end
  end

  // PID follows the toggle at request time
  always_ff @(posedge clock) begin
    if (send_start) begin
      usb_type_o <= toggle_i ? usb_bulk_pkg::PID_DATA1 : usb_bulk_pkg::PID_DATA0;
    end
  end

endmodule

/* source/handshake_issuer.sv */
`timescale 1ns/10ps
module handshake_issuer (
  input  logic                      clock,
  input  logic                      reset,
  input  usb_bulk_pkg::bulk_state_t state_i,
  input  logic                      usb_tvalid_i,
  input  logic                      blk_tready_i,
  input  logic                      usb_tlast_i,
  input  logic                      hsk_sent_i,
  output logic                      usb_tready_o,
  output logic                      hsk_send_o,
  output logic [1:0]                hsk_type_o
);

  logic out_state;
  logic last_beat;

  // Sink back-pressure only while accepting
  // Draining and every other state keep the decoder flowing
  assign usb_tready_o = state_i == usb_bulk_pkg::out_rx ? blk_tready_i : 1'b1;

  assign out_state = state_i == usb_bulk_pkg::out_rx ||
                     state_i == usb_bulk_pkg::out_drain;
  assign last_beat = usb_tvalid_i && usb_tready_o && usb_tlast_i;

  // Request goes up the cycle after the last OUT beat
  // and stays up until the encoder reports it sent
  always_ff @(posedge clock) begin
    if (reset) begin
      hsk_send_o <= 1'b0;
    end else if (!hsk_send_o) begin
      hsk_send_o <= out_state && last_beat;
    end else if (hsk_sent_i) begin
      hsk_send_o <= 1'b0;
    end
  end

  // ACK when the sink took the data, NAK after a drain
  // Held stable while the request is up
  always_ff @(posedge clock) begin
    if (!hsk_send_o && out_state && last_beat) begin
      if (state_i == usb_bulk_pkg::out_rx) begin
        hsk_type_o <= usb_bulk_pkg::HSK_ACK;
      end else begin
        hsk_type_o <= usb_bulk_pkg::HSK_NAK;
      end
    end
  end

endmodule

/* bulk/bulk_transfer_fsm.sv */
`timescale 1ns/10ps
module bulk_transfer_fsm (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     start_i,
  input  usb_bulk_pkg::trans_dir_t dir_i,
  input  logic                     ready_i,
  input  logic                     in_last_done_i,
  input  logic                     usb_busy_i,
  input  logic                     usb_tvalid_i,
  input  logic                     usb_tready_o_i,
  input  logic                     usb_tlast_i,
  input  logic                     hsk_recv_i,
  input  logic [1:0]               hsk_type_i,
  input  logic                     hsk_sent_i,
  output usb_bulk_pkg::bulk_state_t state_o,
  output logic                     busy_o,
  output logic                     toggle_o
);

  logic out_last_beat;

  // Last byte of the OUT packet taken from the decoder
  assign out_last_beat = usb_tvalid_i && usb_tready_o_i && usb_tlast_i;

  // Token dispatch holds off while a transaction runs
  assign busy_o = state_o != usb_bulk_pkg::idle;

  // Transaction state
  always_ff @(posedge clock) begin
    if (reset) begin
      state_o <= usb_bulk_pkg::idle;
    end else begin
      case (state_o)
        usb_bulk_pkg::idle: begin
          // Ready sampled at the token picks data or ZDP, accept or drain
          if (start_i) begin
            if (dir_i == usb_bulk_pkg::dir_in) begin
              state_o <= ready_i ? usb_bulk_pkg::in_tx : usb_bulk_pkg::in_zdp;
            end else begin
              state_o <= ready_i ? usb_bulk_pkg::out_rx : usb_bulk_pkg::out_drain;
            end
          end
        end

        usb_bulk_pkg::in_tx: begin
          // Last byte has left the skid register
          if (in_last_done_i) begin
            state_o <= usb_bulk_pkg::in_ack;
          end
        end

        usb_bulk_pkg::in_zdp: begin
          // Encoder took the empty packet
          if (usb_busy_i) begin
            state_o <= usb_bulk_pkg::in_ack;
          end
        end

        usb_bulk_pkg::in_ack: begin
          // Host answers with ACK or NAK
          if (hsk_recv_i) begin
            state_o <= usb_bulk_pkg::done;
          end
        end

        usb_bulk_pkg::out_rx: begin
          if (out_last_beat) begin
            state_o <= usb_bulk_pkg::out_ack;
          end
        end

        usb_bulk_pkg::out_drain: begin
          if (out_last_beat) begin
            state_o <= usb_bulk_pkg::out_nak;
          end
        end

        usb_bulk_pkg::out_ack, usb_bulk_pkg::out_nak: begin
          if (hsk_sent_i) begin
            state_o <= usb_bulk_pkg::done;
          end
        end

        default: begin
          // done, back to idle next cycle
          state_o <= usb_bulk_pkg::idle;
        end
      endcase
    end
  end

  // Shared DATA0/DATA1 toggle
  // Host ACK on IN, or our own ACK sent on OUT
  always_ff @(posedge clock) begin
    if (reset) begin
      toggle_o <= 1'b0;
    end else if (state_o == usb_bulk_pkg::in_ack && hsk_recv_i &&
                 hsk_type_i == usb_bulk_pkg::HSK_ACK) begin
      toggle_o <= ~toggle_o;
    end else if (state_o == usb_bulk_pkg::out_ack && hsk_sent_i) begin
      toggle_o <= ~toggle_o;
    end
  end

endmodule

/* source/token_dispatch.sv */
`timescale 1ns/10ps
module token_dispatch (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [6:0]              usb_addr_i,
  input  logic                    tok_recv_i,
  input  logic [1:0]              tok_type_i,
  input  logic [6:0]              tok_addr_i,
  input  logic [3:0]              tok_endp_i,
  input  logic                    busy_i,
  input  logic                    blk_in_ready_i,
  input  logic                    blk_out_ready_i,
  output logic                    start_o,
  output usb_bulk_pkg::trans_dir_t dir_o,
  output logic                    ready_o
);

  logic is_data_tok;
  logic tok_match;

  // Only IN and OUT tokens open a bulk transaction
  always_comb begin
    case (tok_type_i)
      usb_bulk_pkg::TOK_IN, usb_bulk_pkg::TOK_OUT: is_data_tok = 1'b1;
      usb_bulk_pkg::TOK_SETUP, usb_bulk_pkg::TOK_SOF: is_data_tok = 1'b0;
      default: is_data_tok = 1'b0;
    endcase
  end

  // Address and endpoint must both match
  // A start already in flight also counts as busy
  assign tok_match = tok_recv_i && is_data_tok && !busy_i && !start_o &&
                     tok_addr_i == usb_addr_i &&
                     tok_endp_i == usb_bulk_pkg::BULK_ENDPOINT;

  // One-cycle start pulse, one clock after the token
  always_ff @(posedge clock) begin
    if (reset) begin
      start_o <= 1'b0;
    end else begin
      start_o <= tok_match;
    end
  end

  // Direction and stream readiness, sampled at the token
  always_ff @(posedge clock) begin
    if (tok_match) begin
      if (tok_type_i == usb_bulk_pkg::TOK_IN) begin
        dir_o   <= usb_bulk_pkg::dir_in;
        ready_o <= blk_in_ready_i;
      end else begin
        dir_o   <= usb_bulk_pkg::dir_out;
        ready_o <= blk_out_ready_i;
      end
    end
  end

endmodule

/* common/usb_bulk_pkg.sv */
package usb_bulk_pkg;

  // Token types from the packet decoder
  localparam logic [1:0] TOK_OUT = 2'b00;
  localparam logic [1:0] TOK_SOF = 2'b01;
  localparam logic [1:0] TOK_IN = 2'b10;
  localparam logic [1:0] TOK_SETUP = 2'b11;

  // Handshake codes, both directions
  localparam logic [1:0] HSK_ACK = 2'b00;
  localparam logic [1:0] HSK_NAK = 2'b10;

  // Data packet codes toward the encoder
  localparam logic [1:0] PID_DATA0 = 2'b00;
  localparam logic [1:0] PID_DATA1 = 2'b10;

  // The one bulk endpoint this engine serves
  localparam logic [3:0] BULK_ENDPOINT = 4'd1;

  // Stream byte width
  localparam int BYTE_W = 8;

  // Bulk transaction states
  typedef enum {
    idle,
    in_tx,
    in_zdp,
    in_ack,
    out_rx,
    out_drain,
    out_ack,
    out_nak,
    done
  } bulk_state_t;

  // Direction of a started transaction
  typedef enum logic {dir_in, dir_out} trans_dir_t;

endpackage
